// File: dec_pkg.sv
// decode stage package
// opcodes, operator and select encodings, widths, credit depth
// and the decoded record handed downstream
package dec_pkg;

  localparam int unsigned XLEN         = 32;
  localparam int unsigned REG_ADDR_W   = 5;
  localparam int unsigned DEC_CREDITS  = 4;  // credits held by consumer after reset
  localparam int unsigned CREDIT_CNT_W = 3;  // must hold 0..DEC_CREDITS

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    // branch compares
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_IMM, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J,
    IMM_INCR_PC,  // constant 4, link address
    IMM_Z         // zero-extended rs1 field
  } imm_sel_e;

  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MIE       = 12'h304,
    CSR_DCSR      = 12'h7b0,
    CSR_DPC       = 12'h7b1,
    CSR_DSCRATCH0 = 12'h7b2,
    CSR_DSCRATCH1 = 12'h7b3
  } csr_num_e;

  typedef enum logic [1:0] {MEM_WORD = 2'b00, MEM_HALF = 2'b01, MEM_BYTE = 2'b10} mem_type_e;

  //////////////////////////////
  // records
  //////////////////////////////

  typedef struct packed {
    logic ecall;
    logic ebreak;
    logic mret;
    logic dret;
    logic wfi;
  } sys_flags_t;

  typedef struct packed {
    alu_op_e                alu_op;
    op_a_sel_e              op_a_sel;
    op_b_sel_e              op_b_sel;
    logic [XLEN-1:0]        imm;
    logic [REG_ADDR_W-1:0]  raddr_a;    // rs1
    logic [REG_ADDR_W-1:0]  raddr_b;    // rs2
    logic [REG_ADDR_W-1:0]  waddr;      // rd
    logic                   rf_we;
    logic                   data_req;   // load/store
    logic                   data_we;    // store
    mem_type_e              data_type;
    logic                   data_sext;  // signed load
    logic                   jump;
    logic                   branch;
    logic                   csr_access;
    csr_op_e                csr_op;
    logic                   csr_flush;
    sys_flags_t             sys;
    logic                   illegal;
  } dec_out_t;

endpackage

// File: imm_extract.sv
// register field and immediate extraction
// builds the immediate of the format picked by the opcode decoder
`timescale 1ns/1ps

module imm_extract import dec_pkg::*; (
  input  logic [XLEN-1:0]       instr_i,
  input  imm_sel_e              imm_sel_i,
  output logic [REG_ADDR_W-1:0] raddr_a_o,
  output logic [REG_ADDR_W-1:0] raddr_b_o,
  output logic [REG_ADDR_W-1:0] waddr_o,
  output logic [XLEN-1:0]       imm_o
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_z;

  assign raddr_a_o = instr_i[19:15];  // rs1
  assign raddr_b_o = instr_i[24:20];  // rs2
  assign waddr_o   = instr_i[11:7];   // rd

  // all formats sign-extend from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_z = {{(XLEN-REG_ADDR_W){1'b0}}, instr_i[19:15]};  // csr uimm

  always_comb begin
    case (imm_sel_i)
      IMM_I:       imm_o = imm_i;
      IMM_S:       imm_o = imm_s;
      IMM_B:       imm_o = imm_b;
      IMM_U:       imm_o = imm_u;
      IMM_J:       imm_o = imm_j;
      IMM_INCR_PC: imm_o = 32'd4;  // next pc offset
      IMM_Z:       imm_o = imm_z;
      default:     imm_o = '0;
    endcase
  end

endmodule

// File: opcode_decoder.sv
// RV32I opcode and funct decode
// operator, operand selects, load/store, jump/branch, system and csr control;
// side effects of illegal encodings are squashed
`timescale 1ns/1ps

module opcode_decoder import dec_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output imm_sel_e        imm_sel_o,
  output dec_out_t        dec_o,         // reg fields, imm and csr fields filled at top
  output csr_op_e         csr_op_raw_o,  // before set/clear fixup
  output logic            csr_access_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       illegal;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  always_comb begin
    dec_o          = '0;
    dec_o.alu_op   = ALU_SLTU;
    dec_o.op_a_sel = OP_A_IMM;
    dec_o.op_b_sel = OP_B_IMM;
    dec_o.data_type = MEM_WORD;
    imm_sel_o      = IMM_I;
    csr_op_raw_o   = CSR_OP_READ;
    csr_access_o   = 1'b0;
    illegal        = 1'b0;

    unique case (opcode)
      //////////////////////////////
      // jumps and branches
      //////////////////////////////
      OPCODE_JAL: begin  // target pc + imm_j, link written directly
        dec_o.jump     = 1'b1;
        dec_o.op_a_sel = OP_A_CURRPC;
        imm_sel_o      = IMM_J;
        dec_o.alu_op   = ALU_ADD;
        dec_o.rf_we    = 1'b1;
      end
      OPCODE_JALR: begin
        dec_o.jump     = 1'b1;
        dec_o.op_a_sel = OP_A_REG_A;  // rs1 + imm_i
        dec_o.alu_op   = ALU_ADD;
        dec_o.rf_we    = 1'b1;
        if (funct3 != 3'b000) illegal = 1'b1;
      end
      OPCODE_BRANCH: begin
        // selects give the target, operator carries the condition
        dec_o.branch   = 1'b1;
        dec_o.op_a_sel = OP_A_CURRPC;
        imm_sel_o      = IMM_B;
        unique case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      //////////////////////////////
      // load / store
      //////////////////////////////
      OPCODE_STORE: begin
        dec_o.op_a_sel = OP_A_REG_A;
        dec_o.alu_op   = ALU_ADD;
        dec_o.data_req = 1'b1;
        dec_o.data_we  = 1'b1;
        imm_sel_o      = IMM_S;
        if (funct3[2]) illegal = 1'b1;  // no register offset
        unique case (funct3[1:0])
          2'b00:   dec_o.data_type = MEM_BYTE;
          2'b01:   dec_o.data_type = MEM_HALF;
          2'b10:   dec_o.data_type = MEM_WORD;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        dec_o.op_a_sel  = OP_A_REG_A;
        dec_o.alu_op    = ALU_ADD;
        dec_o.data_req  = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.data_sext = ~funct3[2];  // LBU/LHU zero-extend
        unique case (funct3[1:0])
          2'b00: dec_o.data_type = MEM_BYTE;
          2'b01: dec_o.data_type = MEM_HALF;
          2'b10: begin
            dec_o.data_type = MEM_WORD;
            if (funct3[2]) illegal = 1'b1;  // LWU is RV64 only
          end
          default: illegal = 1'b1;
        endcase
      end

      //////////////////////////////
      // alu
      //////////////////////////////
      OPCODE_LUI: begin  // 0 + imm_u
        dec_o.op_a_sel = OP_A_ZERO;
        imm_sel_o      = IMM_U;
        dec_o.alu_op   = ALU_ADD;
        dec_o.rf_we    = 1'b1;
      end
      OPCODE_AUIPC: begin
        dec_o.op_a_sel = OP_A_CURRPC;
        imm_sel_o      = IMM_U;
        dec_o.alu_op   = ALU_ADD;
        dec_o.rf_we    = 1'b1;
      end
      OPCODE_OP_IMM: begin
        dec_o.op_a_sel = OP_A_REG_A;
        dec_o.rf_we    = 1'b1;
        unique case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op = ALU_SLL;
            if (instr_i[31:25] != 7'b0) illegal = 1'b1;
          end
          default: begin  // 101, srli / srai by funct7
            if (instr_i[31:25] == 7'b000_0000) dec_o.alu_op = ALU_SRL;
            else if (instr_i[31:25] == 7'b010_0000) dec_o.alu_op = ALU_SRA;
            else illegal = 1'b1;
          end
        endcase
      end
      OPCODE_OP: begin
        dec_o.op_a_sel = OP_A_REG_A;
        dec_o.op_b_sel = OP_B_REG_B;
        dec_o.rf_we    = 1'b1;
        // funct7 == 1 (mul/div) falls through to illegal
        unique case ({instr_i[31:25], funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          default:         illegal = 1'b1;
        endcase
      end

      //////////////////////////////
      // fence and system
      //////////////////////////////
      OPCODE_MISC_MEM: begin
        dec_o.alu_op = ALU_ADD;
        if (funct3 == 3'b000) begin  // fence as nop
          dec_o.op_a_sel = OP_A_REG_A;
        end else if (funct3 == 3'b001) begin  // fence.i jumps to pc + 4
          dec_o.jump     = 1'b1;
          dec_o.op_a_sel = OP_A_CURRPC;
          imm_sel_o      = IMM_INCR_PC;
        end else begin
          illegal = 1'b1;
        end
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          dec_o.op_a_sel = OP_A_REG_A;
          unique case (instr_i[31:20])  // funct12
            12'h000: dec_o.sys.ecall  = 1'b1;
            12'h001: dec_o.sys.ebreak = 1'b1;
            12'h302: dec_o.sys.mret   = 1'b1;
            12'h7b2: dec_o.sys.dret   = 1'b1;
            12'h105: dec_o.sys.wfi    = 1'b1;
            default: illegal = 1'b1;
          endcase
          if (instr_i[19:15] != '0 || instr_i[11:7] != '0) illegal = 1'b1;
        end else begin
          csr_access_o = 1'b1;
          dec_o.rf_we  = 1'b1;
          // uimm forms take zero-extended rs1 as operand a
          dec_o.op_a_sel = funct3[2] ? OP_A_IMM : OP_A_REG_A;
          imm_sel_o      = funct3[2] ? IMM_Z : IMM_I;
          unique case (funct3[1:0])
            2'b01:   csr_op_raw_o = CSR_OP_WRITE;
            2'b10:   csr_op_raw_o = CSR_OP_SET;
            2'b11:   csr_op_raw_o = CSR_OP_CLEAR;
            default: illegal = 1'b1;  // funct3 100
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase

    // illegal encodings must not reach rf, lsu, pc or csrs
    if (illegal) begin
      dec_o.rf_we    = 1'b0;
      dec_o.data_req = 1'b0;
      dec_o.data_we  = 1'b0;
      dec_o.jump     = 1'b0;
      dec_o.branch   = 1'b0;
      csr_access_o   = 1'b0;
    end
    dec_o.illegal = illegal;
  end

endmodule

// File: csr_decoder.sv
// CSR operation fixup and flush detection
// set/clear with rs1 == 0 only reads; writes to interrupt enables
// and debug CSRs request a pipeline flush
`timescale 1ns/1ps

module csr_decoder import dec_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic            csr_access_i,
  input  csr_op_e         csr_op_raw_i,
  output csr_op_e         csr_op_o,
  output logic            csr_flush_o
);

  csr_num_e csr_num;
  logic     is_irq_csr;  // mstatus / mie
  logic     is_dbg_csr;

  assign csr_num = csr_num_e'(instr_i[31:20]);

  assign is_irq_csr = (csr_num == CSR_MSTATUS) || (csr_num == CSR_MIE);
  assign is_dbg_csr = (csr_num == CSR_DCSR)      || (csr_num == CSR_DPC) ||
                      (csr_num == CSR_DSCRATCH0) || (csr_num == CSR_DSCRATCH1);

  // x0 / zero uimm never modifies the csr
  always_comb begin
    csr_op_o = csr_op_raw_i;
    if ((csr_op_raw_i == CSR_OP_SET || csr_op_raw_i == CSR_OP_CLEAR) &&
        instr_i[19:15] == '0) begin
      csr_op_o = CSR_OP_READ;
    end
  end

  // enabling irqs needs a flush so pending irqs are seen next cycle
  always_comb begin
    csr_flush_o = 1'b0;
    if (csr_access_i) begin
      if ((csr_op_o == CSR_OP_WRITE || csr_op_o == CSR_OP_SET) && is_irq_csr) begin
        csr_flush_o = 1'b1;
      end
      if (csr_op_o != CSR_OP_READ && is_dbg_csr) begin  // any debug csr modify
        csr_flush_o = 1'b1;
      end
    end
  end

endmodule

// File: credit_out_buf.sv
// output register for decoded records
// credit counter tracks free downstream slots, one record per credit
`timescale 1ns/1ps

module credit_out_buf import dec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_valid_i,
  input  dec_out_t push_data_i,
  output logic     push_ready_o,
  output logic     dec_valid_o,
  output dec_out_t dec_o,
  input  logic     credit_return_i
);

  logic [CREDIT_CNT_W-1:0] credit_cnt;
  logic                    accept;

  assign push_ready_o = (credit_cnt != '0);  // stall only when out of credits
  assign accept       = push_valid_i & push_ready_o;

  //////////////////////////////
  // credit counter
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt <= CREDIT_CNT_W'(DEC_CREDITS);
    end else begin
      case ({accept, credit_return_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // record sent
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // slot freed
        default: credit_cnt <= credit_cnt;         // none, or both cancel
      endcase
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= accept;  // single-cycle pulse per record
    end
  end

  // payload, qualified by dec_valid_o
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_o <= push_data_i;
    end
  end

endmodule

// File: rv_decode_top.sv
// registered RV32I decode stage
// combinational decode chain into a credit-controlled output register
`timescale 1ns/1ps

module rv_decode_top import dec_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  output logic            in_ready_o,
  output logic            dec_valid_o,
  output dec_out_t        dec_o,
  input  logic            credit_return_i
);

  imm_sel_e              imm_sel;
  logic [REG_ADDR_W-1:0] raddr_a, raddr_b, waddr;
  logic [XLEN-1:0]       imm;
  dec_out_t              dec_raw;
  dec_out_t              dec_rec;  // merged record
  csr_op_e               csr_op_raw, csr_op;
  logic                  csr_access, csr_flush;

  imm_extract u_imm_extract (
    .instr_i   (instr_i),
    .imm_sel_i (imm_sel),
    .raddr_a_o (raddr_a),
    .raddr_b_o (raddr_b),
    .waddr_o   (waddr),
    .imm_o     (imm)
  );

  opcode_decoder u_opcode_decoder (
    .instr_i      (instr_i),
    .imm_sel_o    (imm_sel),
    .dec_o        (dec_raw),
    .csr_op_raw_o (csr_op_raw),
    .csr_access_o (csr_access)
  );

  csr_decoder u_csr_decoder (
    .instr_i      (instr_i),
    .csr_access_i (csr_access),
    .csr_op_raw_i (csr_op_raw),
    .csr_op_o     (csr_op),
    .csr_flush_o  (csr_flush)
  );

  // fill in fields owned by the extract and csr blocks
  always_comb begin
    dec_rec            = dec_raw;
    dec_rec.imm        = imm;
    dec_rec.raddr_a    = raddr_a;
    dec_rec.raddr_b    = raddr_b;
    dec_rec.waddr      = waddr;
    dec_rec.csr_access = csr_access;
    dec_rec.csr_op     = csr_op;
    dec_rec.csr_flush  = csr_flush;
  end

  credit_out_buf u_credit_out_buf (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_valid_i    (instr_valid_i),
    .push_data_i     (dec_rec),
    .push_ready_o    (in_ready_o),
    .dec_valid_o     (dec_valid_o),
    .dec_o           (dec_o),
    .credit_return_i (credit_return_i)
  );

endmodule

// File: rv_decode_properties.sv
// credit handshake assertions for the decode output buffer
// counter bound, no push without credit, one-cycle output latency
`timescale 1ns/1ps

module rv_decode_properties import dec_pkg::*; (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    push_valid_i,
  input logic                    push_ready_i,
  input logic                    dec_valid_i,
  input logic [CREDIT_CNT_W-1:0] credit_cnt_i
);

  logic accept;

  assign accept = push_valid_i && push_ready_i;

  cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_i <= CREDIT_CNT_W'(DEC_CREDITS))
    else $error("credit counter above the credit limit");

  // an empty counter lets no record out of the buffer
  no_push_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (credit_cnt_i == '0) |=> !dec_valid_i)
    else $error("record sent with no credit left");

  // output pulse exactly one cycle after each acceptance
  valid_after_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> dec_valid_i)
    else $error("accepted record missing at the output");

  valid_needs_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i |-> $past(accept))
    else $error("output valid without an acceptance one cycle before");

endmodule

bind credit_out_buf rv_decode_properties u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .push_valid_i (push_valid_i),
  .push_ready_i (push_ready_o),
  .dec_valid_i  (dec_valid_o),
  .credit_cnt_i (credit_cnt)
);

// File: tb_rv_decode.sv
// testbench for the registered RV32I decode stage
// directed and random instructions, reference decode, credit consumer model
`timescale 1ns/1ps

module tb_rv_decode import dec_pkg::*; ();

  logic            clk_i;
  logic            rst_n_i;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_i;
  logic            in_ready_o;
  logic            dec_valid_o;
  dec_out_t        dec_o;
  logic            credit_return_i;

  logic [31:0] lcg_state = 32'd56799;
  dec_out_t    exp_q [$];         // expected records, in acceptance order
  int          cyc_q [$];         // cycle each record is due
  int          cycle = 0;
  int          rx_cnt = 0;        // records seen at the output
  int          accepted = 0;      // instructions taken by the DUT
  int          returned = 0;      // credits handed back
  int          checks = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  logic        hold = 1'b0;       // consumer keeps its credits
  logic        aborted = 1'b0;

  localparam int N_DIRECTED = 32;
  localparam logic [31:0] DIRECTED [N_DIRECTED] = '{
    32'h00000013, 32'h40315093, 32'h02311093, 32'h02208033,  // alu, shifts, mul
    32'h402081b3, 32'h0080a283, 32'h0080c283, 32'h0080e283,  // sub, lw, lbu, lwu
    32'h0080b283, 32'hfe20ae23, 32'h010000ef, 32'h000100e7,  // ld, sw, jal, jalr
    32'h000110e7, 32'h12345037, 32'h00001117, 32'h0ff0000f,
    32'h0000100f, 32'h00000073, 32'h00100073, 32'h30200073,  // fence.i, ecall ..
    32'h7b200073, 32'h10500073, 32'h000000f3, 32'h00200073,
    32'h300020f3, 32'h30409073, 32'h7b1130f3, 32'h30046073,  // csr forms
    32'h7b0070f3, 32'h30004073, 32'hfe208ce3, 32'h0020a063   // beq, bad branch
  };
  // common opcodes weighted up plus two unused encodings
  localparam logic [6:0] OPC_TAB [16] = '{
    7'h03, 7'h0f, 7'h13, 7'h17, 7'h23, 7'h33, 7'h37, 7'h63,
    7'h67, 7'h6f, 7'h73, 7'h13, 7'h33, 7'h73, 7'h00, 7'h7f
  };
  localparam logic [11:0] CSR_TAB [8] = '{
    12'h300, 12'h304, 12'h7b0, 12'h7b1, 12'h7b2, 12'h7b3, 12'h302, 12'h105
  };

  rv_decode_top UUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .in_ready_o      (in_ready_o),
    .dec_valid_o     (dec_valid_o),
    .dec_o           (dec_o),
    .credit_return_i (credit_return_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  //////////////////////////////
  // stimulus and reference
  //////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_instr();
    logic [31:0] r;
    logic [31:0] s;
    r = lcg_next();
    s = lcg_next();
    r[6:0] = OPC_TAB[s[3:0]];
    if (s[4]) r[31:25] = s[5] ? 7'h20 : 7'h00;  // mostly legal funct7
    if (r[6:0] == OPCODE_SYSTEM) begin
      if (s[6]) r[19:15] = 5'd0;            // set/clear to read
      if (s[7]) r[31:20] = CSR_TAB[s[10:8]];
    end
    return r;
  endfunction

  function automatic mem_type_e mem_size(input logic [1:0] w);
    if (w == 2'd0) return MEM_BYTE;
    if (w == 2'd1) return MEM_HALF;
    return MEM_WORD;
  endfunction

  function automatic dec_out_t ref_decode(input logic [31:0] ins);
    dec_out_t    d;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rs1;
    logic [11:0] f12;
    logic        bad;
    f3  = ins[14:12];
    f7  = ins[31:25];
    rs1 = ins[19:15];
    f12 = ins[31:20];
    bad = 1'b0;
    d           = '0;
    d.alu_op    = ALU_SLTU;  // idle values
    d.op_a_sel  = OP_A_IMM;
    d.op_b_sel  = OP_B_IMM;
    d.data_type = MEM_WORD;
    d.imm       = {{20{ins[31]}}, ins[31:20]};  // I format unless replaced
    d.raddr_a   = rs1;
    d.raddr_b   = ins[24:20];
    d.waddr     = ins[11:7];
    case (ins[6:0])
      OPCODE_JAL: begin
        d.alu_op   = ALU_ADD;
        d.op_a_sel = OP_A_CURRPC;
        d.imm      = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        d.jump     = 1'b1;
        d.rf_we    = 1'b1;
      end
      OPCODE_JALR: begin
        d.alu_op   = ALU_ADD;
        d.op_a_sel = OP_A_REG_A;
        d.jump     = 1'b1;
        d.rf_we    = 1'b1;
        bad        = (f3 != 3'd0);
      end
      OPCODE_BRANCH: begin
        d.op_a_sel = OP_A_CURRPC;
        d.imm      = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        d.branch   = 1'b1;
        case (f3)
          3'd0:    d.alu_op = ALU_EQ;
          3'd1:    d.alu_op = ALU_NE;
          3'd4:    d.alu_op = ALU_LT;
          3'd5:    d.alu_op = ALU_GE;
          3'd6:    d.alu_op = ALU_LTU;
          3'd7:    d.alu_op = ALU_GEU;
          default: bad = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        d.alu_op    = ALU_ADD;
        d.op_a_sel  = OP_A_REG_A;
        d.data_req  = 1'b1;
        d.rf_we     = 1'b1;
        d.data_sext = ~f3[2];
        d.data_type = mem_size(f3[1:0]);
        bad         = (f3[1:0] == 2'd3) || (f3 == 3'b110);  // size 3 or lwu
      end
      OPCODE_STORE: begin
        d.alu_op    = ALU_ADD;
        d.op_a_sel  = OP_A_REG_A;
        d.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        d.data_req  = 1'b1;
        d.data_we   = 1'b1;
        d.data_type = mem_size(f3[1:0]);
        bad         = f3[2] || (f3[1:0] == 2'd3);
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        d.alu_op   = ALU_ADD;
        d.op_a_sel = (ins[6:0] == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        d.imm      = {ins[31:12], 12'h000};
        d.rf_we    = 1'b1;
      end
      OPCODE_OP_IMM: begin
        d.op_a_sel = OP_A_REG_A;
        d.rf_we    = 1'b1;
        case (f3)
          3'd0: d.alu_op = ALU_ADD;
          3'd2: d.alu_op = ALU_SLT;
          3'd3: d.alu_op = ALU_SLTU;
          3'd4: d.alu_op = ALU_XOR;
          3'd6: d.alu_op = ALU_OR;
          3'd7: d.alu_op = ALU_AND;
          3'd1: begin
            d.alu_op = ALU_SLL;
            bad      = (f7 != 7'h00);
          end
          default: begin
            if (f7 == 7'h00) d.alu_op = ALU_SRL;
            else if (f7 == 7'h20) d.alu_op = ALU_SRA;
            else bad = 1'b1;
          end
        endcase
      end
      OPCODE_OP: begin
        d.op_a_sel = OP_A_REG_A;
        d.op_b_sel = OP_B_REG_B;
        d.rf_we    = 1'b1;
        if (f7 == 7'h00) begin
          case (f3)
            3'd0: d.alu_op = ALU_ADD;
            3'd1: d.alu_op = ALU_SLL;
            3'd2: d.alu_op = ALU_SLT;
            3'd3: d.alu_op = ALU_SLTU;
            3'd4: d.alu_op = ALU_XOR;
            3'd5: d.alu_op = ALU_SRL;
            3'd6: d.alu_op = ALU_OR;
            3'd7: d.alu_op = ALU_AND;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) d.alu_op = ALU_SUB;
        else if (f7 == 7'h20 && f3 == 3'd5) d.alu_op = ALU_SRA;
        else bad = 1'b1;  // includes funct7 == 1
      end
      OPCODE_MISC_MEM: begin
        d.alu_op = ALU_ADD;
        if (f3 == 3'd0) begin
          d.op_a_sel = OP_A_REG_A;
        end else if (f3 == 3'd1) begin  // fence.i jumps to the next pc
          d.op_a_sel = OP_A_CURRPC;
          d.imm      = 32'd4;
          d.jump     = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      OPCODE_SYSTEM: begin
        if (f3 == 3'd0) begin
          d.op_a_sel = OP_A_REG_A;
          case (f12)
            12'h000: d.sys.ecall  = 1'b1;
            12'h001: d.sys.ebreak = 1'b1;
            12'h302: d.sys.mret   = 1'b1;
            12'h7b2: d.sys.dret   = 1'b1;
            12'h105: d.sys.wfi    = 1'b1;
            default: bad = 1'b1;
          endcase
          if (rs1 != 5'd0 || ins[11:7] != 5'd0) bad = 1'b1;
        end else begin
          d.csr_access = 1'b1;
          d.rf_we      = 1'b1;
          d.op_a_sel   = f3[2] ? OP_A_IMM : OP_A_REG_A;
          if (f3[2]) d.imm = {27'd0, rs1};  // uimm
          case (f3[1:0])
            2'd1:    d.csr_op = CSR_OP_WRITE;
            2'd2:    d.csr_op = (rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_SET;
            2'd3:    d.csr_op = (rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_CLEAR;
            default: bad = 1'b1;
          endcase
          d.csr_flush = ((d.csr_op == CSR_OP_WRITE || d.csr_op == CSR_OP_SET) &&
                         (f12 == 12'h300 || f12 == 12'h304)) ||
                        (d.csr_op != CSR_OP_READ && f12 >= 12'h7b0 && f12 <= 12'h7b3);
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin  // no architectural side effects
      d.rf_we      = 1'b0;
      d.data_req   = 1'b0;
      d.data_we    = 1'b0;
      d.jump       = 1'b0;
      d.branch     = 1'b0;
      d.csr_access = 1'b0;
    end
    d.illegal = bad;
    return d;
  endfunction

  //////////////////////////////
  // checking
  //////////////////////////////
  task automatic check_val(input string name, input logic [31:0] act,
                           input logic [31:0] exp);
    checks++;
    if (act !== exp) begin
      $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, act, exp);
      mismatches++;
    end
  endtask

  task automatic compare_record(input dec_out_t act, input dec_out_t exp);
    check_val("dec_o.alu_op", 32'(act.alu_op), 32'(exp.alu_op));
    check_val("dec_o.op_a_sel", 32'(act.op_a_sel), 32'(exp.op_a_sel));
    check_val("dec_o.op_b_sel", 32'(act.op_b_sel), 32'(exp.op_b_sel));
    check_val("dec_o.imm", act.imm, exp.imm);
    check_val("dec_o.raddr_a", 32'(act.raddr_a), 32'(exp.raddr_a));
    check_val("dec_o.raddr_b", 32'(act.raddr_b), 32'(exp.raddr_b));
    check_val("dec_o.waddr", 32'(act.waddr), 32'(exp.waddr));
    check_val("dec_o.rf_we", 32'(act.rf_we), 32'(exp.rf_we));
    check_val("dec_o.data_req", 32'(act.data_req), 32'(exp.data_req));
    check_val("dec_o.data_we", 32'(act.data_we), 32'(exp.data_we));
    check_val("dec_o.data_type", 32'(act.data_type), 32'(exp.data_type));
    check_val("dec_o.data_sext", 32'(act.data_sext), 32'(exp.data_sext));
    check_val("dec_o.jump", 32'(act.jump), 32'(exp.jump));
    check_val("dec_o.branch", 32'(act.branch), 32'(exp.branch));
    check_val("dec_o.csr_access", 32'(act.csr_access), 32'(exp.csr_access));
    check_val("dec_o.csr_op", 32'(act.csr_op), 32'(exp.csr_op));
    check_val("dec_o.csr_flush", 32'(act.csr_flush), 32'(exp.csr_flush));
    check_val("dec_o.sys", 32'(act.sys), 32'(exp.sys));
    check_val("dec_o.illegal", 32'(act.illegal), 32'(exp.illegal));
  endtask

  // output monitor samples mid-cycle
  task automatic watch_outputs();
    dec_out_t exp_rec;
    int       exp_cyc;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && dec_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: output record at %0t with no accepted instruction", $time);
          other_errors++;
        end else begin
          exp_rec = exp_q.pop_front();
          exp_cyc = cyc_q.pop_front();
          if (exp_cyc != cycle) begin
            $display("ERROR: record due in cycle %0d arrived in cycle %0d", exp_cyc, cycle);
            other_errors++;
          end
          compare_record(dec_o, exp_rec);
          rx_cnt++;
        end
      end
    end
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////
  // one clock per call with inputs changed 2 ns after the edge
  task automatic step(input logic vld, input logic [31:0] ins, output logic took);
    logic [31:0] r;
    int          credits;
    @(posedge clk_i);
    #2;
    credits = int'(DEC_CREDITS) - accepted + returned;  // updates landed at this edge
    check_val("in_ready_o", 32'(in_ready_o), 32'(credits != 0));
    r = lcg_next();
    credit_return_i = 1'b0;
    if (!hold && rx_cnt > returned && r[1:0] != 2'b00) begin  // random consumer delay
      credit_return_i = 1'b1;
      returned++;
    end
    instr_valid_i = vld;
    instr_i       = ins;
    took          = vld && in_ready_o;  // taken at the coming edge
    if (took) begin
      accepted++;
      exp_q.push_back(ref_decode(ins));
      cyc_q.push_back(cycle + 1);
    end
  endtask

  task automatic send_instr(input logic [31:0] ins);
    logic took;
    int   tries;
    took  = 1'b0;
    tries = 0;
    while (!took && !aborted) begin
      step(1'b1, ins, took);
      tries++;
      if (!took && tries >= 100) begin
        $display("ERROR: instruction %h not accepted within 100 cycles", ins);
        other_errors++;
        aborted = 1'b1;
      end
    end
  endtask

  task automatic drain();
    logic took;
    int   waited;
    waited = 0;
    while ((exp_q.size() != 0 || rx_cnt != returned) && !aborted) begin
      step(1'b0, '0, took);
      waited++;
      if (waited >= 200) begin
        $display("ERROR: records or credits still outstanding after 200 cycles");
        other_errors++;
        aborted = 1'b1;
      end
    end
    if (!aborted) step(1'b0, '0, took);  // last credit lands
  endtask

  initial begin : main
    logic        took;
    logic [31:0] r;
    int          rx_base;
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    credit_return_i = 1'b0;
    rst_n_i         = 1'b0;
    fork
      watch_outputs();
    join_none
    repeat (3) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    check_val("in_ready_o", 32'(in_ready_o), 32'd1);
    check_val("dec_valid_o", 32'(dec_valid_o), 32'd0);

    for (int i = 0; i < N_DIRECTED; i++) begin
      if (!aborted) send_instr(DIRECTED[i]);
    end
    for (int i = 0; i < 400; i++) begin  // random stream with some idle gaps
      if (!aborted) begin
        r = lcg_next();
        if (r[2:0] == 3'd0) step(1'b0, '0, took);
        else send_instr(rand_instr());
      end
    end

    // credits withheld and then released
    if (!aborted) drain();
    if (!aborted) begin
      hold    = 1'b1;
      rx_base = rx_cnt;
      for (int k = 0; k < int'(DEC_CREDITS) + 4; k++) step(1'b1, rand_instr(), took);
      step(1'b0, '0, took);
      step(1'b0, '0, took);
      check_val("records_while_withheld", 32'(rx_cnt - rx_base), 32'(DEC_CREDITS));
      check_val("in_ready_o", 32'(in_ready_o), 32'd0);
      hold = 1'b0;
      for (int k = 0; k < int'(DEC_CREDITS); k++) begin
        if (!aborted) send_instr(rand_instr());
      end
      if (!aborted) drain();
    end
    if (!aborted) check_val("in_ready_o", 32'(in_ready_o), 32'd1);

    $display("checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim.f
dec_pkg.sv
imm_extract.sv
opcode_decoder.sv
csr_decoder.sv
credit_out_buf.sv
rv_decode_top.sv
rv_decode_properties.sv
tb_rv_decode.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_rv_decode -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  echo "test failed"
  exit 1
fi

echo "test passed"
exit 0
